// ==== src.f ====
+incdir+design
design/spr_pkg.sv
design/vid_pkg.sv
design/mem_bus_if.sv
design/sprite_regs.sv
design/pixmem_arbiter.sv
design/sprite_engine.sv
design/line_buffer.sv
design/sprite_top.sv
test/tb_sprite_top.sv

// ==== Bender.yml ====
package:
  name: sprite_render

sources:
  - include_dirs:
      - design
    files:
      - design/spr_pkg.sv
      - design/vid_pkg.sv
      - design/mem_bus_if.sv
      - design/sprite_regs.sv
      - design/pixmem_arbiter.sv
      - design/sprite_engine.sv
      - design/line_buffer.sv
      - design/sprite_top.sv
  - target: test
    files:
      - test/tb_sprite_top.sv

// ==== test/tb_sprite_top.sv ====
`timescale 1ns/1ns
`include "sprite_cfg.svh"

module tb_sprite_top import spr_pkg::*, vid_pkg::*; ();

	localparam int N_LINES  = 29;	// 2 flush, directed, 12 random, 1 tail
	localparam int LINE_CYC = 1500;	// pulse, engine, 256 strobes, host writes
	localparam int WD_CYC   = N_LINES * LINE_CYC + 1000;	// plus initial load

	logic               clk;
	logic               line_start;
	logic [8:0]         vline;
	logic               cbeg;
	logic               host_we;
	logic               reg_sel;
	logic [`MEM_AW-1:0] host_addr;
	mem_word_t          host_wdata;
	logic [5:0]         spixel;
	logic               spx_en;
	logic               done;

	// mirrors of everything the host wrote
	logic [7:0] attr_m [`SPR_COUNT*8];
	logic [5:0] pal_m  [16];
	mem_word_t  mem_m  [2**`MEM_AW];

	pix_t next_exp [`LINE_W];	// rendered this line
	pix_t cur_exp  [`LINE_W];	// scanned this line
	int   seed = 32'hb56bcd69;
	int   v;
	int   cmp_x;
	bit   chk_on;
	logic cbeg_d;

	sprite_top uut (
		.clk, .line_start, .vline, .cbeg, .host_we, .reg_sel,
		.host_addr, .host_wdata, .spixel, .spx_en, .done
	);

	always #2 clk = ~clk;

	// --------------------------------------------------
	// reference renderer and checker
	// --------------------------------------------------
	function automatic void render_line(input int lv);
		spr_desc_t d;
		int        y, h, npix, pos, k, p;
		mem_word_t w;
		mem_word_t t;
		pix_t      px;
		for (int i = 0; i < `LINE_W; i++)
			next_exp[i] = '0;
		for (int s = 0; s < `SPR_COUNT; s++)
		begin
			d.mode  = spr_mode_e'(attr_m[s*8+A_CTRL][1:0]);
			d.flipx = attr_m[s*8+A_CTRL][CTRL_FLIPX];
			d.x     = attr_m[s*8+A_X];
			d.width = attr_m[s*8+A_W];
			d.base  = `MEM_AW'({attr_m[s*8+A_BASE_H], attr_m[s*8+A_BASE_L]});
			y = attr_m[s*8+A_Y];
			h = attr_m[s*8+A_H];
			if (!(d.mode inside {M_PAL16, M_DIRECT}) || lv < y || lv >= y + h || d.width == 0)
				continue;	// off, not on this line, or empty
			d.row = 8'(lv - y);
			npix = (d.mode == M_DIRECT) ? 2 : 4;
			pos = d.flipx ? (d.x + d.width * npix - 1) : d.x;
			for (k = 0; k < d.width; k++)
			begin
				w = mem_m[`MEM_AW'(d.base + d.row * d.width + k)];
				for (p = 0; p < npix; p++)
				begin
					t = w << (p * ((npix == 2) ? 8 : 4));	// msb pixel first
					if (npix == 2)
						px = '{opaque: t[15], color: t[13:8]};
					else
						px = '{opaque: |t[15:12], color: pal_m[t[15:12]]};
					if (px.opaque && pos < `LINE_W)	// clip past right edge
						next_exp[pos] = px;	// later sprite overwrites
					pos = d.flipx ? pos - 1 : pos + 1;
				end
			end
		end
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// outputs settle the edge after cbeg is taken
	always @(posedge clk)
	begin
		if (cbeg_d && chk_on)
		begin
			check_val($sformatf("spx_en[%0d]", cmp_x), spx_en, cur_exp[cmp_x].opaque);
			if (cur_exp[cmp_x].opaque)
				check_val($sformatf("spixel[%0d]", cmp_x), spixel, cur_exp[cmp_x].color);
		end
		if (cbeg_d)
			cmp_x = cmp_x + 1;
		cbeg_d <= cbeg;
	end

	// --------------------------------------------------
	// host and line drivers
	// --------------------------------------------------
	task automatic host_write(input logic sel, input int a, input mem_word_t d);
		@(posedge clk);
		host_we <= 1'b1;
		reg_sel <= sel;
		host_addr <= `MEM_AW'(a);
		host_wdata <= d;
		if (sel && a < 64)
			attr_m[a] = d[7:0];
		else if (sel)
			pal_m[a[3:0]] = d[5:0];
		else
			mem_m[`MEM_AW'(a)] = d;
	endtask

	task automatic host_idle();
		@(posedge clk);
		host_we <= 1'b0;
	endtask

	task automatic set_sprite(input int s, input int x, input int y, input int h,
		input int w, input int ctrl, input int base);
		host_write(1, s*8+A_X, x);
		host_write(1, s*8+A_Y, y);
		host_write(1, s*8+A_H, h);
		host_write(1, s*8+A_W, w);
		host_write(1, s*8+A_CTRL, ctrl);
		host_write(1, s*8+A_BASE_L, base & 255);
		host_write(1, s*8+A_BASE_H, base >> 8);
		host_idle();
	endtask

	task automatic rand_sprite(input int s);
		logic [31:0] r;
		r = $random(seed);
		// y just above the next line so most land visible
		set_sprite(s, r[23:16], (v - r[10:8]) & 255, 1 + r[13:11], 1 + r[15:14],
			{r[7], 5'b0, r[1:0]}, r[31:24]);
	endtask

	task automatic run_line(input bit chk, input bit mid);
		int i;
		@(posedge clk);
		line_start <= 1'b1;
		vline <= 9'(v);
		@(posedge clk);
		line_start <= 1'b0;
		check_val("done", done, 0);	// cleared by line_start
		for (i = 0; i < `LINE_W; i++)
			cur_exp[i] = next_exp[i];
		render_line(v);
		chk_on = chk;
		cmp_x = 0;
		// row 1 of sprite 5 rewritten while row 0 is fetched
		if (mid)
		begin
			for (i = 0; i < 24; i++)
				host_write(0, 12'h1c2 + (i & 1), 16'h1000 + i * 16'h0123);
			host_idle();
		end
		i = 0;
		while (!done && i < 1000)
		begin
			@(posedge clk);
			i++;
		end
		if (!done)
		begin
			$display("engine overran line %0d without finishing", v);
			$display("** FAIL **");
			$fatal(1);
		end
		for (i = 0; i < `LINE_W; i++)
		begin
			@(posedge clk);
			cbeg <= 1'b1;
			@(posedge clk);
			cbeg <= 1'b0;
			repeat (2) @(posedge clk);
		end
		repeat (2) @(posedge clk);
		check_val("done", done, 1);	// held through the scan
		if (chk && cmp_x != `LINE_W)
		begin
			$display("only %0d pixels scanned on line %0d", cmp_x, v);
			$display("** FAIL **");
			$fatal(1);
		end
		v++;
	endtask

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------
	initial
	begin
		repeat (WD_CYC) @(posedge clk);
		$display("simulation ran past its time budget");
		$display("** FAIL **");
		$fatal(1);
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		clk = 1'b0;
		line_start = 1'b1;
		vline = '0;
		cbeg = 1'b0;
		host_we = 1'b0;
		reg_sel = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		cbeg_d = 1'b0;
		chk_on = 1'b0;
		cmp_x = 0;
		v = 0;
		repeat (10) @(posedge clk);
		line_start <= 1'b0;
		for (int i = 0; i < `SPR_COUNT*8; i++)
			host_write(1, i, 0);	// all sprites off
		for (int i = 0; i < 16; i++)
			host_write(1, 64 + i, $random(seed));
		for (int i = 0; i < 512; i++)
			host_write(0, i, $random(seed));
		host_idle();

		run_line(0, 0);	// flush both halves
		run_line(0, 0);
		run_line(1, 0);	// all off

		// single 16-colour sprite with some 0 nibbles
		set_sprite(0, 20, 3, 3, 2, 1, 12'h100);
		host_write(0, 12'h100, 16'h1203);
		host_write(0, 12'h101, 16'h0f0a);
		host_write(0, 12'h102, 16'h4560);
		host_write(0, 12'h104, 16'h00e1);
		host_idle();
		repeat (5) run_line(1, 0);

		// flipped direct sprite over an opaque one
		host_write(1, A_CTRL, 0);
		for (int i = 0; i < 4; i++)
			host_write(0, 12'h140 + i, 16'h1111 * (i + 1));
		for (int i = 0; i < 6; i++)
			host_write(0, 12'h180 + i, 16'h9a17 + i * 16'h0101);	// high bytes opaque
		set_sprite(1, 100, 8, 2, 2, 1, 12'h140);
		set_sprite(2, 98, 8, 2, 3, 8'h82, 12'h180);
		repeat (3) run_line(1, 0);

		// overlap and right edge clip
		host_write(1, 1*8+A_CTRL, 0);
		host_write(1, 2*8+A_CTRL, 0);
		for (int i = 0; i < 4; i++)
			host_write(0, 12'h1b0 + i, 16'h8080 | (i * 16'h0909));
		set_sprite(3, 244, 11, 1, 2, 1, 12'h1a0);
		set_sprite(4, 250, 11, 1, 4, 2, 12'h1b0);
		repeat (2) run_line(1, 0);

		// host writes during fetch
		host_write(1, 3*8+A_CTRL, 0);
		host_write(1, 4*8+A_CTRL, 0);
		set_sprite(5, 60, 13, 2, 2, 1, 12'h1c0);
		run_line(1, 1);
		repeat (2) run_line(1, 0);

		// random lines
		for (int s = 0; s < `SPR_COUNT; s++)
			rand_sprite(s);
		for (int n = 0; n < 12; n++)
		begin
			run_line(1, 0);
			rand_sprite($random(seed) & (`SPR_COUNT - 1));
			host_write(1, 64 + ($random(seed) & 15), $random(seed));
			for (int i = 0; i < 4; i++)
				host_write(0, $random(seed) & 511, $random(seed));
			host_idle();
		end
		run_line(1, 0);	// scans the last random render

		$display("** PASS **");
		$finish;
	end

endmodule

// ==== design/sprite_top.sv ====
`timescale 1ns/1ns
`include "sprite_cfg.svh"

module sprite_top import vid_pkg::*; (
	input  logic               clk,
	input  logic               line_start,	// also async reset
	input  logic [8:0]         vline,
	input  logic               cbeg,
	input  logic               host_we,
	input  logic               reg_sel,	// 1 regs, 0 pixel memory
	input  logic [`MEM_AW-1:0] host_addr,
	input  mem_word_t          host_wdata,
	output logic [5:0]         spixel,
	output logic               spx_en,
	output logic               done
);

	logic [5:0] attr_ra;
	logic [7:0] attr_rd;
	logic [3:0] pal_ra;
	logic [5:0] pal_rd;
	logic       wr_en;
	logic [7:0] wr_x;
	pix_t       wr_pix;

	mem_bus_if mbus ();	// fetcher to pixel memory

	// --------------------------------------------------
	// host storage
	// --------------------------------------------------
	sprite_regs u_regs (
		.clk, .host_we, .reg_sel, .host_addr, .host_wdata,
		.attr_ra, .attr_rd, .pal_ra, .pal_rd
	);

	pixmem_arbiter u_arb (
		.clk, .line_start, .host_we, .reg_sel, .host_addr, .host_wdata,
		.bus (mbus.mem)
	);

	// --------------------------------------------------
	// render and scan
	// --------------------------------------------------
	sprite_engine u_eng (
		.clk, .line_start, .vline, .attr_ra, .attr_rd, .pal_ra, .pal_rd,
		.bus (mbus.fetch),
		.wr_en, .wr_x, .wr_pix, .done
	);

	line_buffer u_lbuf (
		.clk, .line_start, .vline, .wr_en, .wr_x, .wr_pix,
		.cbeg, .spixel, .spx_en
	);

endmodule

// ==== design/line_buffer.sv ====
`timescale 1ns/1ns
`include "sprite_cfg.svh"

module line_buffer import vid_pkg::*; (
	input  logic       clk,
	input  logic       line_start,
	input  logic [8:0] vline,
	input  logic       wr_en,
	input  logic [7:0] wr_x,
	input  pix_t       wr_pix,
	input  logic       cbeg,
	output logic [5:0] spixel,
	output logic       spx_en
);

	localparam int XW = $clog2(`LINE_W);

	pix_t half0 [`LINE_W];
	pix_t half1 [`LINE_W];

	logic          wsel;	// half taking engine writes
	logic [XW-1:0] scan_x;
	logic          clr_cyc;	// cycle after cbeg
	pix_t          scan_rd;

	assign wsel    = vline[0];
	assign scan_rd = wsel ? half0[scan_x] : half1[scan_x];	// the other half

	// --------------------------------------------------
	// one write port per half: render or clear
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!wsel && wr_en)
			half0[wr_x] <= wr_pix;
		else if (wsel && clr_cyc)
			half0[scan_x] <= '0;	// wipe behind the read
		if (wsel && wr_en)
			half1[wr_x] <= wr_pix;
		else if (!wsel && clr_cyc)
			half1[scan_x] <= '0;
	end

	// --------------------------------------------------
	// scan out
	// --------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			scan_x <= '0;
			clr_cyc <= 1'b0;
			spixel <= '0;
			spx_en <= 1'b0;
		end
		else
		begin
			clr_cyc <= cbeg;
			if (cbeg)
			begin
				spixel <= scan_rd.color;
				spx_en <= scan_rd.opaque;
			end
			if (clr_cyc)
				scan_x <= scan_x + 1'b1;
		end
	end

endmodule

// ==== design/sprite_engine.sv ====
`timescale 1ns/1ns
`include "sprite_cfg.svh"

module sprite_engine import spr_pkg::*, vid_pkg::*; (
	input  logic       clk,
	input  logic       line_start,
	input  logic [8:0] vline,
	output logic [5:0] attr_ra,
	input  logic [7:0] attr_rd,
	output logic [3:0] pal_ra,
	input  logic [5:0] pal_rd,
	mem_bus_if.fetch   bus,
	output logic       wr_en,
	output logic [7:0] wr_x,
	output pix_t       wr_pix,
	output logic       done
);

	localparam int SW = $clog2(`SPR_COUNT);
	localparam int AW = `MEM_AW;

	typedef enum logic [3:0] {
		S_CTRL, S_Y, S_H, S_W, S_X, S_BL, S_BH,	// attribute walk
		S_WAIT,		// word fetch
		S_PIX,		// one pixel per cycle
		S_DONE
	} state_e;

	state_e         state;
	logic [SW-1:0]  num;		// current sprite
	attr_idx_e      idx;
	spr_desc_t      desc;
	logic [8:0]     rel;		// vline minus y wraps when above
	logic [7:0]     words_left;
	logic [1:0]     pix_cnt;	// pixels after this one in word
	mem_word_t      word_sr;	// msb pixel first
	logic [10:0]    pos;		// wide so flip never wraps
	logic [9:0]     pix_w;
	logic [AW-1:0]  base_full;
	spr_mode_e      ctrl_mode;
	logic           spr_end;
	pix_t           cur_pix;

	// --------------------------------------------------
	// attribute addressing
	// --------------------------------------------------
	always_comb
	begin
		case (state)
		S_CTRL:  idx = A_CTRL;
		S_Y:     idx = A_Y;
		S_H:     idx = A_H;
		S_W:     idx = A_W;
		S_X:     idx = A_X;
		S_BL:    idx = A_BASE_L;
		S_BH:    idx = A_BASE_H;
		default: idx = A_RSVD;
		endcase
	end

	assign attr_ra   = 6'({num, idx});
	assign ctrl_mode = spr_mode_e'(attr_rd[1:0]);
	assign pix_w     = (desc.mode == M_DIRECT) ? {1'b0, desc.width, 1'b0} : {desc.width, 2'b0};
	assign base_full = AW'({attr_rd, desc.base[7:0]});

	// sprite finished or skipped this cycle
	assign spr_end = ((state == S_CTRL) && (ctrl_mode inside {M_OFF, M_OFF3}))
		|| ((state == S_H) && (rel >= {1'b0, attr_rd}))	// not on this line
		|| ((state == S_W) && (attr_rd == 8'd0))		// zero width so nothing to fetch
		|| ((state == S_PIX) && (pix_cnt == 2'd0) && (words_left == 8'd1));

	// --------------------------------------------------
	// control FSM
	// --------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state <= S_CTRL;
			num <= '0;
			bus.req <= 1'b0;
			words_left <= '0;
			pix_cnt <= '0;
		end
		else if (spr_end)
		begin
			state <= (&num) ? S_DONE : S_CTRL;
			num <= num + 1'b1;
		end
		else
		begin
			case (state)
			S_CTRL: state <= S_Y;
			S_Y:    state <= S_H;
			S_H:    state <= S_W;
			S_W:    state <= S_X;
			S_X:    state <= S_BL;
			S_BL:   state <= S_BH;
			S_BH:
			begin
				bus.req <= 1'b1;	// first word of row
				words_left <= desc.width;
				state <= S_WAIT;
			end
			S_WAIT:
				if (bus.strobe)
				begin
					bus.req <= 1'b0;
					pix_cnt <= (desc.mode == M_DIRECT) ? 2'd1 : 2'd3;
					state <= S_PIX;
				end
			S_PIX:
				if (pix_cnt != 2'd0)
					pix_cnt <= pix_cnt - 2'd1;
				else
				begin
					words_left <= words_left - 8'd1;
					bus.req <= 1'b1;	// next word
					state <= S_WAIT;
				end
			S_DONE: state <= S_DONE;	// hold till line_start
			default: state <= S_DONE;
			endcase
		end
	end

	// --------------------------------------------------
	// descriptor, address and pixel datapath
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		case (state)
		S_CTRL:
		begin
			desc.mode <= ctrl_mode;
			desc.flipx <= attr_rd[CTRL_FLIPX];
		end
		S_Y:  rel <= vline - {1'b0, attr_rd};
		S_H:  desc.row <= rel[7:0];	// visible so fits 8 bits
		S_W:  desc.width <= attr_rd;
		S_X:  desc.x <= attr_rd;
		S_BL:
		begin
			desc.base <= AW'(attr_rd);
			// flipped rows start at the right end
			pos <= desc.flipx ? ({3'b0, desc.x} + {1'b0, pix_w} - 11'd1) : {3'b0, desc.x};
		end
		S_BH:
		begin
			desc.base <= base_full;
			bus.addr <= base_full + AW'(desc.row) * AW'(desc.width);
		end
		S_WAIT:
			if (bus.strobe)
			begin
				word_sr <= bus.rdata;
				bus.addr <= bus.addr + 1'b1;	// req drops same edge
			end
		S_PIX:
		begin
			word_sr <= (desc.mode == M_DIRECT) ? (word_sr << 8) : (word_sr << 4);
			pos <= desc.flipx ? (pos - 11'd1) : (pos + 11'd1);
		end
		default: ;
		endcase
	end

	// --------------------------------------------------
	// line buffer write
	// --------------------------------------------------
	assign pal_ra = word_sr[15:12];

	always_comb
	begin
		if (desc.mode == M_DIRECT)
		begin
			cur_pix.opaque = word_sr[15];
			cur_pix.color = word_sr[13:8];
		end
		else
		begin
			cur_pix.opaque = |word_sr[15:12];	// index 0 see-through
			cur_pix.color = pal_rd;
		end
	end

	assign wr_en  = (state == S_PIX) && cur_pix.opaque && (pos < `LINE_W);	// clip right
	assign wr_x   = pos[7:0];
	assign wr_pix = cur_pix;
	assign done   = (state == S_DONE);

	// no fetch left open once the line is done
	a_done_idle: assert property (@(posedge clk) disable iff (line_start)
		done |-> !bus.req);

endmodule

// ==== design/pixmem_arbiter.sv ====
`timescale 1ns/1ns
`include "sprite_cfg.svh"

module pixmem_arbiter import vid_pkg::*; (
	input  logic               clk,
	input  logic               line_start,
	input  logic               host_we,
	input  logic               reg_sel,
	input  logic [`MEM_AW-1:0] host_addr,
	input  mem_word_t          host_wdata,
	mem_bus_if.mem             bus
);

	mem_word_t pix_mem [2**`MEM_AW];

	logic host_wr;	// host owns the port this cycle
	logic grant;	// fetcher read this cycle
	logic pending;	// granted but strobe not yet sent

	assign host_wr = host_we && !reg_sel;
	// host first and the fetcher waits a cycle per host write
	assign grant = bus.req && !host_wr && !pending;

	// --------------------------------------------------
	// single port array
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (host_wr)
			pix_mem[host_addr] <= host_wdata;
		else if (grant)
			bus.rdata <= pix_mem[bus.addr];	// valid with strobe
	end

	// strobe one cycle after grant
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			bus.strobe <= 1'b0;
			pending <= 1'b0;
		end
		else
		begin
			bus.strobe <= grant;
			if (grant)
				pending <= 1'b1;	// req still high during strobe cycle
			else if (bus.strobe)
				pending <= 1'b0;
		end
	end

	// fetcher keeps req and addr steady until its strobe
	a_req_held: assert property (@(posedge clk) disable iff (line_start)
		bus.strobe |-> (bus.req && $stable(bus.addr)));

endmodule

// ==== design/sprite_regs.sv ====
`timescale 1ns/1ns
`include "sprite_cfg.svh"

module sprite_regs import vid_pkg::*; (
	input  logic               clk,
	input  logic               host_we,
	input  logic               reg_sel,
	input  logic [`MEM_AW-1:0] host_addr,
	input  mem_word_t          host_wdata,
	input  logic [5:0]         attr_ra,	// {sprite, byte}
	output logic [7:0]         attr_rd,
	input  logic [3:0]         pal_ra,
	output logic [5:0]         pal_rd
);

	localparam int AW = $clog2(`SPR_COUNT) + 3;	// attribute byte address bits

	logic [7:0] attr_mem [`SPR_COUNT*8];
	logic [5:0] pal_mem  [16];

	logic attr_hit;
	logic pal_hit;

	// --------------------------------------------------
	// host decode, register space only
	// --------------------------------------------------
	assign attr_hit = host_we && reg_sel && (host_addr < `SPR_COUNT*8);
	assign pal_hit  = host_we && reg_sel && (host_addr >= 64);	// 64 and up

	always_ff @(posedge clk)
	begin
		if (attr_hit)
			attr_mem[host_addr[AW-1:0]] <= host_wdata[7:0];
		if (pal_hit)
			pal_mem[host_addr[3:0]] <= host_wdata[5:0];	// low byte, 6 colour bits
	end

	// --------------------------------------------------
	// engine reads, no clock
	// --------------------------------------------------
	assign attr_rd = attr_mem[attr_ra[AW-1:0]];
	assign pal_rd  = pal_mem[pal_ra];

endmodule

// ==== design/mem_bus_if.sv ====
`timescale 1ns/1ns
`include "sprite_cfg.svh"

// read port from sprite fetcher into the shared pixel memory
interface mem_bus_if import vid_pkg::*; ();

	logic               req;	// held until strobe
	logic [`MEM_AW-1:0] addr;	// steady while req
	logic               strobe;	// one cycle, data valid
	mem_word_t          rdata;

	// fetcher side
	modport fetch (
		output req,
		output addr,
		input  strobe,
		input  rdata
	);

	// memory side
	modport mem (
		input  req,
		input  addr,
		output strobe,
		output rdata
	);

endinterface

// ==== design/vid_pkg.sv ====
package vid_pkg;

	// --------------------------------------------------
	// line buffer entry
	// --------------------------------------------------
	typedef struct packed {
		logic       opaque;	// 0 means nothing drawn here
		logic [5:0] color;
	} pix_t;

	// --------------------------------------------------
	// pixel memory
	// --------------------------------------------------

	// one word holds 4 palette nibbles or 2 direct bytes
	typedef logic [15:0] mem_word_t;

endpackage

// ==== design/spr_pkg.sv ====
`include "sprite_cfg.svh"

package spr_pkg;

	// byte offsets inside one 8-byte attribute record
	typedef enum logic [2:0] {
		A_X      = 3'd0,	// left x position
		A_Y      = 3'd1,	// top line
		A_H      = 3'd2,	// height in lines
		A_W      = 3'd3,	// width in words
		A_CTRL   = 3'd4,	// mode, flip
		A_BASE_L = 3'd5,
		A_BASE_H = 3'd6,
		A_RSVD   = 3'd7		// spare
	} attr_idx_e;

	// control bits 1:0
	typedef enum logic [1:0] {
		M_OFF    = 2'd0,
		M_PAL16  = 2'd1,	// 4 nibbles per word through palette
		M_DIRECT = 2'd2,	// 2 bytes per word, bit 7 opaque
		M_OFF3   = 2'd3		// treated as off too
	} spr_mode_e;

	localparam int CTRL_FLIPX = 7;	// control byte

	// latched sprite, one at a time
	typedef struct packed {
		logic [7:0]         x;
		logic [7:0]         row;	// line inside sprite
		logic [7:0]         width;	// words per row
		spr_mode_e          mode;
		logic               flipx;
		logic [`MEM_AW-1:0] base;
	} spr_desc_t;

endpackage

// ==== design/sprite_cfg.svh ====
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// --------------------------------------------------
// sprite renderer sizing
// --------------------------------------------------

// sprites in the attribute file, power of two up to 8
`define SPR_COUNT 8

// visible pixels per line, x field is 8 bits
`define LINE_W 256

// pixel memory word address width
`define MEM_AW 12

`endif
